/* common/jy_defines.svh */
// Bus widths, register addresses and fixed values shared by the mapper RTL and its testbench
`ifndef JY_DEFINES_SVH
`define JY_DEFINES_SVH

// Bus widths
`define JY_DATA_W      8
`define JY_PRG_AIN_W   16
`define JY_CHR_AIN_W   14
`define JY_AOUT_W      22

// Value seen on an unmapped CPU read
`define JY_OPEN_BUS    8'hFF

// Shift-add iterations for an 8x8 product
`define JY_MUL_STEPS   8

// Top PRG address bits of the 8K work-RAM window
`define JY_PRG_RAM_PAGE 9'b1_1110_0000

// Readable registers
`define JY_ADDR_MUL_LO  16'h5800
`define JY_ADDR_MUL_HI  16'h5801
`define JY_ADDR_ACCUM   16'h5802
`define JY_ADDR_ACCTEST 16'h5803

`endif

/* common/jy_pkg.sv */
// Register field types shared by all mapper RTL blocks, referenced as jy_pkg::name
`include "jy_defines.svh"

package jy_pkg;

	typedef logic [`JY_DATA_W-1:0] data_t;

	typedef data_t [3:0] prg_banks_t;            // $8000-$8003

	typedef logic [2*`JY_DATA_W-1:0] chr_bank_t; // High byte from $A00x, low from $900x

	typedef chr_bank_t [7:0] chr_banks_t;

	// Mode register at $D000
	typedef struct packed {
		logic       prg_rom_6xxx;  // Bit 7, ROM instead of RAM at $6000
		logic [1:0] spare;         // Bits 6:5
		logic [1:0] chr_size;      // 8K, 4K, 2K, 1K slots
		logic       prg_fixed_off; // Clear forces last slot to bank FF
		logic [1:0] prg_size;      // 32K, 16K, 8K, 8K reversed
	} bank_mode_t;

	// IRQ mode register at $C001
	typedef struct packed {
		logic       count_down;    // Bit 7
		logic       count_up;      // Bit 6
		logic [2:0] spare;         // Bits 5:3
		logic       prescale_3bit; // Bit 2
		logic [1:0] source;        // 00 CPU cycle, 11 CPU write
	} irq_mode_t;

endpackage

/* source/jy_regs.sv */
// CPU register file of the mapper, decodes writes from $5800 up and drives the readback bus
`include "jy_defines.svh"

module jy_regs (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     ce,
	input  logic                     prg_write,
	input  logic [`JY_PRG_AIN_W-1:0] prg_ain,
	input  jy_pkg::data_t            prg_din,
	input  logic [2*`JY_DATA_W-1:0]  product,
	output jy_pkg::data_t            prg_dout,
	output logic                     prg_bus_write,
	output jy_pkg::prg_banks_t       prg_bank,
	output jy_pkg::chr_banks_t       chr_bank,
	output jy_pkg::bank_mode_t       bank_mode,
	output logic [1:0]               mirroring,
	output jy_pkg::data_t            outer_bank,
	output logic                     mul_start,
	output jy_pkg::data_t            mul_a,
	output jy_pkg::data_t            mul_b,
	output jy_pkg::irq_mode_t        irq_mode,
	output logic                     irq_en_req,
	output logic                     irq_dis_req,
	output logic                     prescaler_load,
	output logic                     count_load,
	output jy_pkg::data_t            load_val
);

	jy_pkg::data_t accum;
	jy_pkg::data_t accumtest;
	jy_pkg::data_t irq_xor;   // Key applied to prescaler and count loads

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prg_bank       <= '0;
			chr_bank       <= '0;
			bank_mode      <= '0; // Also brings back the fixed last bank
			mirroring      <= '0;
			outer_bank     <= '0;
			mul_start      <= 1'b0;
			mul_a          <= '0;
			mul_b          <= '0;
			accum          <= '0;
			accumtest      <= '0;
			irq_mode       <= '0;
			irq_xor        <= '0;
			irq_en_req     <= 1'b0;
			irq_dis_req    <= 1'b0;
			prescaler_load <= 1'b0;
			count_load     <= 1'b0;
			load_val       <= '0;
		end else begin
			mul_start      <= 1'b0; // Strobes last one clock
			irq_en_req     <= 1'b0;
			irq_dis_req    <= 1'b0;
			prescaler_load <= 1'b0;
			count_load     <= 1'b0;
			if (ce && prg_write) begin
				casez ({prg_ain[15:11], prg_ain[2:0]})
					8'b01011_?00: mul_a <= prg_din;                        // $5800
					8'b01011_?01: begin                                    // $5801
						mul_b     <= prg_din;
						mul_start <= 1'b1;
					end
					8'b01011_?10: accum <= accum + prg_din;                // $5802
					8'b01011_?11: begin                                    // $5803
						accum     <= '0;
						accumtest <= prg_din;
					end
					8'b10000_???: prg_bank[prg_ain[1:0]] <= prg_din;       // $8000-$8003
					8'b10010_???: chr_bank[prg_ain[2:0]][7:0] <= prg_din;  // $9000-$9007
					8'b10100_???: chr_bank[prg_ain[2:0]][15:8] <= prg_din; // $A000-$A007
					8'b11000_000: begin                                    // $C000
						irq_en_req  <= prg_din[0];
						irq_dis_req <= !prg_din[0];
					end
					8'b11000_001: irq_mode <= jy_pkg::irq_mode_t'(prg_din); // $C001
					8'b11000_010: irq_dis_req <= 1'b1;                      // $C002
					8'b11000_011: irq_en_req <= 1'b1;                       // $C003
					8'b11000_100: begin                                     // $C004
						prescaler_load <= 1'b1;
						load_val       <= prg_din ^ irq_xor;
					end
					8'b11000_101: begin                                     // $C005
						count_load <= 1'b1;
						load_val   <= prg_din ^ irq_xor;
					end
					8'b11000_110: irq_xor <= prg_din;                       // $C006
					8'b11010_?00: bank_mode <= jy_pkg::bank_mode_t'(prg_din); // $D000
					8'b11010_?01: mirroring <= prg_din[1:0];                // $D001
					8'b11010_?11: outer_bank <= prg_din;                    // $D003
					default: ;
				endcase
			end
		end
	end

	// Readback, all other addresses are open bus
	always_comb begin
		prg_bus_write = 1'b1;
		case (prg_ain)
			`JY_ADDR_MUL_LO:  prg_dout = product[7:0];
			`JY_ADDR_MUL_HI:  prg_dout = product[15:8];
			`JY_ADDR_ACCUM:   prg_dout = accum;
			`JY_ADDR_ACCTEST: prg_dout = accumtest;
			default: begin
				prg_dout      = `JY_OPEN_BUS;
				prg_bus_write = 1'b0;
			end
		endcase
	end

endmodule

/* source/jy_prg_map.sv */
// CPU to PRG address translation with bank sizes, fixed last bank and the $6000 RAM window
`include "jy_defines.svh"

module jy_prg_map (
	input  logic [`JY_PRG_AIN_W-1:0] prg_ain,
	input  logic                     prg_write,
	input  jy_pkg::prg_banks_t       prg_bank,
	input  jy_pkg::bank_mode_t       bank_mode,
	input  jy_pkg::data_t            outer_bank,
	output logic [`JY_AOUT_W-1:0]    prg_aout,
	output logic                     prg_allow
);

	logic          prg_6xxx;
	logic          prg_ram;
	logic [1:0]    prg_reg;   // Which of the four bank registers
	jy_pkg::data_t bank_val;
	logic [6:0]    bank_order;
	logic [5:0]    prg_sel;

	assign prg_6xxx = (prg_ain[15:13] == 3'b011);
	assign prg_ram  = prg_6xxx && !bank_mode.prg_rom_6xxx;

	always_comb begin
		casez ({prg_6xxx, bank_mode.prg_size})
			3'b000:  prg_reg = 2'b11;                // 32K
			3'b001:  prg_reg = {prg_ain[14], 1'b1};  // 16K
			3'b01?:  prg_reg = prg_ain[14:13];       // 8K
			default: prg_reg = 2'b11;                // $6000 uses the last register
		endcase
	end

	// Last slot pinned to bank FF unless the fixed bank is switched off
	assign bank_val = (!bank_mode.prg_fixed_off && prg_reg == 2'b11) ? 8'hFF : prg_bank[prg_reg];

	always_comb begin
		bank_order = bank_val[6:0];
		if (bank_mode.prg_size == 2'b11) begin
			for (int i = 0; i < 7; i++) begin
				bank_order[i] = bank_val[6-i]; // Reversed bank numbering
			end
		end
	end

	always_comb begin
		casez ({prg_6xxx, bank_mode.prg_size})
			3'b000:  prg_sel = {bank_order[3:0], prg_ain[14:13]};
			3'b001:  prg_sel = {bank_order[4:0], prg_ain[13]};
			3'b?1?:  prg_sel = bank_order[5:0];
			3'b100:  prg_sel = {bank_order[3:0], 2'b11};
			default: prg_sel = {bank_order[4:0], 1'b1};
		endcase
	end

	assign prg_aout = prg_ram ? {`JY_PRG_RAM_PAGE, prg_ain[12:0]}
	                          : {1'b0, outer_bank[2:1], prg_sel, prg_ain[12:0]};

	// RAM takes writes, ROM is read only
	assign prg_allow = prg_ram || ((prg_ain >= 16'h6000) && !prg_write);

endmodule

/* source/jy_chr_map.sv */
// PPU to CHR address translation with bank sizes, outer bank bits and nametable mirroring
`include "jy_defines.svh"

module jy_chr_map (
	input  logic [`JY_CHR_AIN_W-1:0] chr_ain,
	input  jy_pkg::chr_banks_t       chr_bank,
	input  jy_pkg::bank_mode_t       bank_mode,
	input  logic [1:0]               mirroring,
	input  jy_pkg::data_t            outer_bank,
	output logic [`JY_AOUT_W-1:0]    chr_aout,
	output logic                     vram_a10,
	output logic                     vram_ce
);

	logic [2:0] chr_reg;  // Bank register for this slot
	logic [8:0] chr_val;  // Higher bank bits never reach the output
	logic [8:0] chr_sel;

	always_comb begin
		case (bank_mode.chr_size)
			2'b00: chr_reg = 3'b000;                       // 8K
			2'b01: chr_reg = {chr_ain[12], 1'b0, 1'b0};    // 4K, latch held low
			2'b10: chr_reg = {chr_ain[12:11], 1'b0};       // 2K
			2'b11: chr_reg = chr_ain[12:10];               // 1K
		endcase
	end

	assign chr_val = chr_bank[chr_reg][8:0];

	// Low bank bits below the slot size come from the address
	always_comb begin
		case (bank_mode.chr_size)
			2'b00: chr_sel = {chr_val[5:0], chr_ain[12:10]};
			2'b01: chr_sel = {chr_val[6:0], chr_ain[11:10]};
			2'b10: chr_sel = {chr_val[7:0], chr_ain[10]};
			2'b11: chr_sel = chr_val;
		endcase
	end

	assign chr_aout = {2'b10, outer_bank[3], outer_bank[5] ? chr_sel[8] : outer_bank[0],
	                   chr_sel[7:0], chr_ain[9:0]};

	always_comb begin
		case (mirroring)
			2'b00: vram_a10 = chr_ain[10]; // Vertical
			2'b01: vram_a10 = chr_ain[11]; // Horizontal
			2'b10: vram_a10 = 1'b0;        // Single screen A
			2'b11: vram_a10 = 1'b1;        // Single screen B
		endcase
	end

	assign vram_ce = chr_ain[13]; // Nametable space goes to internal VRAM

endmodule

/* source/jy_multiplier.sv */
// Sequential shift-add multiplier behind the $5800/$5801 registers, restartable by start
`include "jy_defines.svh"

module jy_multiplier (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  jy_pkg::data_t           a,
	input  jy_pkg::data_t           b,
	output logic [2*`JY_DATA_W-1:0] product
);

	logic [2*`JY_DATA_W-1:0] shift_a;
	logic [`JY_MUL_STEPS:0]  bindex;  // One-hot bit of b, top bit means done

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bindex  <= '0;
			bindex[`JY_MUL_STEPS] <= 1'b1; // Idle
			product <= '0;
			shift_a <= '0;
		end else if (start) begin
			bindex  <= (`JY_MUL_STEPS+1)'(2);
			product <= {8'h00, b[0] ? a : 8'h00}; // First partial product
			shift_a <= {7'h00, a, 1'b0};
		end else if (!bindex[`JY_MUL_STEPS]) begin
			if ((bindex[`JY_MUL_STEPS-1:0] & b) != '0)
				product <= product + shift_a;
			bindex  <= bindex << 1;
			shift_a <= shift_a << 1;
		end
	end

endmodule

/* irq/jy_irq_counter.sv */
// IRQ prescaler and 8-bit counter, driven by the $C00x request strobes from the register block
`include "jy_defines.svh"

module jy_irq_counter (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              ce,
	input  logic              prg_write,
	input  jy_pkg::irq_mode_t irq_mode,
	input  logic              irq_en_req,
	input  logic              irq_dis_req,
	input  logic              prescaler_load,
	input  logic              count_load,
	input  jy_pkg::data_t     load_val,
	output logic              irq
);

	jy_pkg::data_t prescaler;
	jy_pkg::data_t counter;
	jy_pkg::data_t step;      // +1 or -1
	logic          pending;
	logic          enabled;
	logic          cnt_src;
	logic          counting;
	logic          pre_wrap;
	logic          cnt_wrap;

	always_comb begin
		case (irq_mode.source)
			2'b00:   cnt_src = ce;              // Every CPU cycle
			2'b11:   cnt_src = ce && prg_write; // CPU writes
			default: cnt_src = 1'b0;            // PPU sources not built
		endcase
	end

	// Both or neither direction bit set stops counting
	assign counting = irq_mode.count_up != irq_mode.count_down;
	assign step     = irq_mode.count_up ? 8'h01 : 8'hFF;

	always_comb begin
		if (irq_mode.count_up) begin
			pre_wrap = irq_mode.prescale_3bit ? (prescaler[2:0] == 3'h7) : (prescaler == 8'hFF);
			cnt_wrap = (counter == 8'hFF);
		end else begin
			pre_wrap = irq_mode.prescale_3bit ? (prescaler[2:0] == 3'h0) : (prescaler == 8'h00);
			cnt_wrap = (counter == 8'h00);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prescaler <= '0;
			counter   <= '0;
			pending   <= 1'b0;
			enabled   <= 1'b0;
		end else begin
			if (prescaler_load)
				prescaler <= load_val;
			if (count_load)
				counter <= load_val;

			if (cnt_src && enabled && counting) begin
				prescaler <= prescaler + step;
				if (pre_wrap) begin
					counter <= counter + step;
					if (cnt_wrap)
						pending <= 1'b1; // Counter rolled over
				end
			end

			// Disable wins over any step in the same clock
			if (irq_dis_req) begin
				pending   <= 1'b0;
				prescaler <= '0;
				enabled   <= 1'b0;
			end else if (irq_en_req) begin
				enabled <= 1'b1;
			end
		end
	end

	assign irq = pending && enabled;

endmodule

/* source/jy_mapper.sv */
// Mapper top level, connects the CPU register block to the address mappers, multiplier and IRQ
`include "jy_defines.svh"

module jy_mapper (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     ce,            // One pulse per CPU cycle
	input  logic                     prg_write,
	input  logic [`JY_PRG_AIN_W-1:0] prg_ain,
	input  jy_pkg::data_t            prg_din,
	input  logic [`JY_CHR_AIN_W-1:0] chr_ain,
	output logic [`JY_AOUT_W-1:0]    prg_aout,
	output jy_pkg::data_t            prg_dout,
	output logic                     prg_bus_write, // Mapper drives the data bus
	output logic                     prg_allow,
	output logic [`JY_AOUT_W-1:0]    chr_aout,
	output logic                     vram_a10,
	output logic                     vram_ce,
	output logic                     irq
);

	jy_pkg::prg_banks_t          prg_bank;
	jy_pkg::chr_banks_t          chr_bank;
	jy_pkg::bank_mode_t          bank_mode;
	logic [1:0]                  mirroring;
	jy_pkg::data_t               outer_bank;
	logic                        mul_start;
	jy_pkg::data_t               mul_a;
	jy_pkg::data_t               mul_b;
	logic [2*`JY_DATA_W-1:0]     product;
	jy_pkg::irq_mode_t           irq_mode;
	logic                        irq_en_req;
	logic                        irq_dis_req;
	logic                        prescaler_load;
	logic                        count_load;
	jy_pkg::data_t               load_val;

	jy_regs u_regs (
		.clk(clk), .rst_n(rst_n), .ce(ce),
		.prg_write(prg_write), .prg_ain(prg_ain), .prg_din(prg_din),
		.product(product),
		.prg_dout(prg_dout), .prg_bus_write(prg_bus_write),
		.prg_bank(prg_bank), .chr_bank(chr_bank), .bank_mode(bank_mode),
		.mirroring(mirroring), .outer_bank(outer_bank),
		.mul_start(mul_start), .mul_a(mul_a), .mul_b(mul_b),
		.irq_mode(irq_mode), .irq_en_req(irq_en_req), .irq_dis_req(irq_dis_req),
		.prescaler_load(prescaler_load), .count_load(count_load), .load_val(load_val)
	);

	jy_prg_map u_prg_map (
		.prg_ain(prg_ain), .prg_write(prg_write), .prg_bank(prg_bank),
		.bank_mode(bank_mode), .outer_bank(outer_bank),
		.prg_aout(prg_aout), .prg_allow(prg_allow)
	);

	jy_chr_map u_chr_map (
		.chr_ain(chr_ain), .chr_bank(chr_bank), .bank_mode(bank_mode),
		.mirroring(mirroring), .outer_bank(outer_bank),
		.chr_aout(chr_aout), .vram_a10(vram_a10), .vram_ce(vram_ce)
	);

	jy_multiplier u_multiplier (
		.clk(clk), .rst_n(rst_n), .start(mul_start),
		.a(mul_a), .b(mul_b), .product(product)
	);

	jy_irq_counter u_irq_counter (
		.clk(clk), .rst_n(rst_n), .ce(ce), .prg_write(prg_write),
		.irq_mode(irq_mode), .irq_en_req(irq_en_req), .irq_dis_req(irq_dis_req),
		.prescaler_load(prescaler_load), .count_load(count_load), .load_val(load_val),
		.irq(irq)
	);

endmodule

/* bench/tb_clock.sv */
// Clock and reset source for the mapper testbench, instantiated once by the testbench top
module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Release on a falling edge, clear of the DUT's active edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* bench/tb_jy_mapper.sv */
// Testbench top that drives the mapper's CPU and PPU buses and checks it with assertions
`include "jy_defines.svh"

module tb_jy_mapper;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PERIOD_NS    = 40;
	localparam int RESET_CYCLES = 10;
	localparam int MUL_RUNS     = 8;
	localparam int ACC_BYTES    = 6;
	localparam int PROBES       = 8;
	localparam int IRQ_QUIET    = 24;
	// Two clocks per register write, one per probe
	localparam int TEST_CYCLES  = RESET_CYCLES + PROBES + 2 + MUL_RUNS * 16 + ACC_BYTES * 2 + 4
		+ 4 * (14 + PROBES) + 2 * (36 + PROBES) + 4 * (2 + PROBES) + 30 + IRQ_QUIET;
	localparam int WATCHDOG_NS  = (TEST_CYCLES + 100) * PERIOD_NS;

	logic clk, rst_n, ce, prg_write;
	logic [15:0] prg_ain;
	logic [13:0] chr_ain;
	logic [21:0] prg_aout, chr_aout;
	jy_pkg::data_t prg_din, prg_dout;
	logic prg_bus_write, prg_allow, vram_a10, vram_ce, irq;
	int check_count, error_count;

	// Register contents as programmed over the CPU bus
	jy_pkg::data_t exp_prg_bank [4];
	logic [15:0]   exp_chr_bank [8];
	jy_pkg::data_t exp_outer;
	logic [1:0]    exp_prg_size, exp_chr_size, exp_mirror;
	logic          exp_fixed_off;

	tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
		.clk(clk), .rst_n(rst_n)
	);

	jy_mapper dut (
		.clk(clk), .rst_n(rst_n), .ce(ce), .prg_write(prg_write), .prg_ain(prg_ain),
		.prg_din(prg_din), .chr_ain(chr_ain), .prg_aout(prg_aout), .prg_dout(prg_dout),
		.prg_bus_write(prg_bus_write), .prg_allow(prg_allow), .chr_aout(chr_aout),
		.vram_a10(vram_a10), .vram_ce(vram_ce), .irq(irq)
	);

	task automatic log_mismatch(input string msg);
		error_count++;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endtask

	assert property (@(posedge clk) disable iff (!rst_n)
		prg_bus_write == (prg_ain[15:2] == 14'h1600))
		else log_mismatch($sformatf("prg_bus_write %b at %h", prg_bus_write, prg_ain));
	assert property (@(posedge clk) vram_ce == chr_ain[13])
		else log_mismatch($sformatf("vram_ce %b for chr_ain %h", vram_ce, chr_ain));

	function automatic logic [21:0] prg_expect(input logic [15:0] addr);
		logic [1:0]    slot;
		jy_pkg::data_t bank;
		logic [5:0]    sel;
		if (addr[15:13] == 3'b011)
			return {`JY_PRG_RAM_PAGE, addr[12:0]}; // Work RAM window at $6000
		case (exp_prg_size)
			2'd0:    slot = 2'd3;
			2'd1:    slot = {addr[14], 1'b1};
			default: slot = addr[14:13];
		endcase
		bank = (slot == 2'd3 && !exp_fixed_off) ? 8'hFF : exp_prg_bank[slot];
		if (exp_prg_size == 2'd3)
			bank = {bank[7], bank[0], bank[1], bank[2], bank[3], bank[4], bank[5], bank[6]};
		case (exp_prg_size)
			2'd0:    sel = {bank[3:0], addr[14:13]};
			2'd1:    sel = {bank[4:0], addr[13]};
			default: sel = bank[5:0];
		endcase
		return {1'b0, exp_outer[2:1], sel, addr[12:0]};
	endfunction

	function automatic logic [21:0] chr_expect(input logic [13:0] addr);
		logic [15:0] bank;
		logic [8:0]  sel;
		if (exp_chr_size == 2'd3) begin
			bank = exp_chr_bank[addr[12:10]]; // 1K slots
			sel  = bank[8:0];
		end else begin
			bank = exp_chr_bank[0];           // One 8K slot
			sel  = {bank[5:0], addr[12:10]};
		end
		return {2'b10, exp_outer[3], exp_outer[5] ? sel[8] : exp_outer[0], sel[7:0], addr[9:0]};
	endfunction

	function automatic logic mirror_expect(input logic [13:0] addr);
		case (exp_mirror)
			2'd0:    return addr[10];
			2'd1:    return addr[11];
			2'd2:    return 1'b0;
			default: return 1'b1;
		endcase
	endfunction

	task automatic cpu_write(input logic [15:0] addr, input jy_pkg::data_t data);
		@(negedge clk);
		prg_ain   = addr;
		prg_din   = data;
		prg_write = 1'b1;
		@(negedge clk);
		prg_write = 1'b0;
	endtask

	task automatic read_expect(input logic [15:0] addr, input jy_pkg::data_t value, input logic drv);
		@(negedge clk);
		prg_write = 1'b0;
		prg_ain   = addr;
		#5;
		check_count++;
		assert (prg_dout == value && prg_bus_write == drv)
			else log_mismatch($sformatf("read %h gave %h/%b, expected %h/%b",
				addr, prg_dout, prg_bus_write, value, drv));
	endtask

	task automatic prg_check(input logic [15:0] addr, input logic wr);
		@(negedge clk);
		prg_write = wr;   // Only used at $6000, where nothing is decoded
		prg_ain   = addr;
		#5;
		check_count++;
		assert (prg_aout == prg_expect(addr) && prg_allow == (addr[15:13] == 3'b011 || !wr))
			else log_mismatch($sformatf("prg_aout %h allow %b at %h write %b, expected %h",
				prg_aout, prg_allow, addr, wr, prg_expect(addr)));
	endtask

	task automatic chr_check(input logic [13:0] addr);
		@(negedge clk);
		chr_ain = addr;
		#5;
		check_count++;
		assert (chr_aout == chr_expect(addr) && vram_a10 == mirror_expect(addr))
			else log_mismatch($sformatf("chr_aout %h vram_a10 %b at %h, expected %h %b",
				chr_aout, vram_a10, addr, chr_expect(addr), mirror_expect(addr)));
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		jy_pkg::data_t a, b, x, sum;
		logic [15:0]   addr, product;
		logic          seen;
		void'($urandom(32'hfd6e));
		ce = 1'b0;
		prg_write = 1'b0;
		prg_ain = 16'h0000;
		prg_din = 8'h00;
		chr_ain = 14'h0000;
		exp_prg_bank = '{default: 8'h00};
		exp_chr_bank = '{default: 16'h0000};
		exp_outer = 8'h00;
		exp_prg_size = 2'd0;
		exp_chr_size = 2'd0;
		exp_mirror = 2'd0;
		exp_fixed_off = 1'b0;
		wait (rst_n);
		@(negedge clk);
		ce = 1'b1;        // One CPU cycle per clock

		check_count++;
		assert (!irq) else log_mismatch("irq high after reset");
		repeat (PROBES) begin
			addr = 16'($urandom);
			if (addr[15:2] != 14'h1600)
				read_expect(addr, `JY_OPEN_BUS, 1'b0);
		end
		prg_check(16'h8000, 1'b0);

		repeat (MUL_RUNS) begin
			a = 8'($urandom);
			b = 8'($urandom);
			product = 16'(a) * 16'(b);
			cpu_write(`JY_ADDR_MUL_LO, a);
			cpu_write(`JY_ADDR_MUL_HI, b);
			repeat (10) @(negedge clk);
			read_expect(`JY_ADDR_MUL_LO, product[7:0], 1'b1);
			read_expect(`JY_ADDR_MUL_HI, product[15:8], 1'b1);
		end

		x = 8'($urandom);
		sum = 8'h00;
		cpu_write(`JY_ADDR_ACCTEST, x);
		repeat (ACC_BYTES) begin
			b = 8'($urandom);
			sum = sum + b;
			cpu_write(`JY_ADDR_ACCUM, b);
		end
		read_expect(`JY_ADDR_ACCTEST, x, 1'b1);
		read_expect(`JY_ADDR_ACCUM, sum, 1'b1);

		for (int m = 0; m < 4; m++) begin
			exp_prg_size  = m[1] ? 2'd3 : 2'd0;
			exp_fixed_off = m[0];
			cpu_write(16'hD000, {5'b00000, exp_fixed_off, exp_prg_size});
			for (int i = 0; i < 4; i++) begin
				exp_prg_bank[i] = 8'($urandom);
				cpu_write(16'h8000 + 16'(i), exp_prg_bank[i]);
			end
			exp_outer = 8'($urandom);
			cpu_write(16'hD003, exp_outer);
			repeat (PROBES) prg_check(16'h8000 | 16'($urandom_range(0, 32767)), 1'b0);
			prg_check(16'h6000 | 16'($urandom_range(0, 8191)), 1'b1);
			prg_check(16'h6000 | 16'($urandom_range(0, 8191)), 1'b0);
		end

		exp_prg_size  = 2'd0;
		exp_fixed_off = 1'b0;
		for (int m = 0; m < 2; m++) begin
			exp_chr_size = (m == 0) ? 2'd3 : 2'd0;
			cpu_write(16'hD000, {3'b000, exp_chr_size, 3'b000});
			for (int i = 0; i < 8; i++) begin
				exp_chr_bank[i] = 16'($urandom);
				cpu_write(16'h9000 + 16'(i), exp_chr_bank[i][7:0]);
				cpu_write(16'hA000 + 16'(i), exp_chr_bank[i][15:8]);
			end
			exp_outer = 8'($urandom);
			cpu_write(16'hD003, exp_outer);
			repeat (PROBES) chr_check(14'($urandom));
		end

		for (int m = 0; m < 4; m++) begin
			exp_mirror = 2'(m);
			cpu_write(16'hD001, {6'b000000, exp_mirror});
			repeat (PROBES) chr_check(14'($urandom));
		end

		cpu_write(16'hC006, 8'h00);
		cpu_write(16'hC004, 8'hFF);
		cpu_write(16'hC005, 8'hFF);
		cpu_write(16'hC001, 8'h40); // Count up on CPU cycles
		cpu_write(16'hC003, 8'h00);
		seen = 1'b0;
		for (int i = 0; i < 4 && !seen; i++) begin
			@(negedge clk);
			seen = irq;
		end
		check_count++;
		assert (seen) else log_mismatch("irq did not rise within 4 clocks of the enable");
		cpu_write(16'hC002, 8'h00);
		seen = 1'b1;
		for (int i = 0; i < 2 && seen; i++) begin
			@(negedge clk);
			seen = irq;
		end
		check_count++;
		assert (!seen) else log_mismatch("irq still high 2 clocks after the disable");

		cpu_write(16'hC001, 8'hC0); // Both direction bits halt the counter
		cpu_write(16'hC004, 8'hFF);
		cpu_write(16'hC005, 8'hFF);
		cpu_write(16'hC003, 8'h00);
		repeat (IRQ_QUIET) begin
			@(negedge clk);
			check_count++;
			assert (!irq) else log_mismatch("irq rose with both count direction bits set");
		end

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* all.f */
+incdir+common
common/jy_pkg.sv
source/jy_regs.sv
source/jy_prg_map.sv
source/jy_chr_map.sv
source/jy_multiplier.sv
irq/jy_irq_counter.sv
source/jy_mapper.sv
bench/tb_clock.sv
bench/tb_jy_mapper.sv

/* Makefile */
# Verilator build and run of the mapper testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
		--top-module tb_jy_mapper -Mdir $(OBJ_DIR) -o tb_jy_mapper

run: compile
	./$(OBJ_DIR)/tb_jy_mapper | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
